/* hdl/game_pkg.sv */
`default_nettype none

package game_pkg;

    // keys the game reacts to, in the order of the held-key map
    typedef enum logic [3:0] {
        KEY_W     = 4'd0,
        KEY_A     = 4'd1,
        KEY_S     = 4'd2,
        KEY_D     = 4'd3,
        KEY_UP    = 4'd4,
        KEY_LEFT  = 4'd5,
        KEY_DOWN  = 4'd6,
        KEY_RIGHT = 4'd7,
        KEY_ENTER = 4'd8,
        KEY_NONE  = 4'd9 // any code we do not track
    } key_idx_e;

    localparam int NUM_KEYS = 9;

    typedef logic [NUM_KEYS-1:0] key_map_t; // one held bit per key index

    // bit 8 marks an extended (E0 prefixed) code
    localparam logic [8:0] W_CODE     = 9'h01D;
    localparam logic [8:0] A_CODE     = 9'h01C;
    localparam logic [8:0] S_CODE     = 9'h01B;
    localparam logic [8:0] D_CODE     = 9'h023;
    localparam logic [8:0] UP_CODE    = 9'h075;
    localparam logic [8:0] LEFT_CODE  = 9'h06B;
    localparam logic [8:0] DOWN_CODE  = 9'h072;
    localparam logic [8:0] RIGHT_CODE = 9'h174; // only right carries the extended flag
    localparam logic [8:0] ENTER_CODE = 9'h05A;

    typedef struct packed {
        logic       is_release; // set for a break code
        logic [8:0] code;
    } key_event_t;

    typedef logic [2:0] level_t;

    localparam level_t MIN_LEVEL = 3'd1;
    localparam level_t MAX_LEVEL = 3'd5;

    // sprite pose numbers, kept as the display side expects them
    typedef enum logic [3:0] {
        POSE_LEFT   = 4'd2,
        POSE_STATIC = 4'd6,
        POSE_RIGHT  = 4'd7,
        POSE_UP     = 4'd8
    } pose_e;

    typedef enum logic [1:0] {
        PHASE_IDLE = 2'd0,
        PHASE_RISE = 2'd1,
        PHASE_FALL = 2'd2
    } jump_phase_e;

    typedef struct packed {
        logic up;
        logic left;
        logic right;
    } player_keys_t;

    typedef struct packed {
        pose_e       pose;
        jump_phase_e phase;
    } player_status_t;

    typedef struct packed {
        logic   playing; // high once enter was taken in the menu
        level_t level;
    } game_status_t;

endpackage

`default_nettype wire

/* hdl/key_map.sv */
`timescale 1ns/1ps
`default_nettype none

// first pipeline stage
// each keyboard strobe sets or clears one bit of the held-key map
module key_map
    import game_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       key_valid, // one cycle per make or break event
    input  key_event_t key_event,
    output key_map_t   key_down
);

    key_idx_e idx; // decoded index of the code on the bus

    // the nine tracked codes are all distinct so a plain case is enough
    always_comb begin
        case (key_event.code)
            W_CODE:     idx = KEY_W;
            A_CODE:     idx = KEY_A;
            S_CODE:     idx = KEY_S;
            D_CODE:     idx = KEY_D;
            UP_CODE:    idx = KEY_UP;
            LEFT_CODE:  idx = KEY_LEFT;
            DOWN_CODE:  idx = KEY_DOWN;
            RIGHT_CODE: idx = KEY_RIGHT;
            ENTER_CODE: idx = KEY_ENTER;
            default:    idx = KEY_NONE; // untracked keys fall through here
        endcase
    end

    // a press sets the bit and a release clears it
    // events for untracked keys leave the map alone
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            key_down <= '0;
        end else if (key_valid && (idx != KEY_NONE)) begin
            key_down[idx] <= ~key_event.is_release;
        end
    end

endmodule

`default_nettype wire

/* hdl/level_menu.sv */
`timescale 1ns/1ps
`default_nettype none

// level select menu
// steps the level once per key press and leaves the menu on enter
module level_menu
    import game_pkg::*;
(
    input  logic         clk,
    input  logic         rst,
    input  key_map_t     key_down,
    output game_status_t status
);

    logic   playing_q;
    level_t level_q;
    logic   armed_q; // one level step allowed until all keys are let go

    logic step_up;
    logic step_down;

    assign step_up   = key_down[KEY_W] | key_down[KEY_UP];
    assign step_down = key_down[KEY_S] | key_down[KEY_DOWN];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            playing_q <= 1'b0;
            level_q   <= MIN_LEVEL;
            armed_q   <= 1'b1;
        end else if (!playing_q) begin
            if (key_down == '0) begin
                armed_q <= 1'b1; // everything released so the next press counts
            end else if (armed_q) begin
                if (step_up) begin
                    if (level_q < MAX_LEVEL)
                        level_q <= level_q + 3'd1;
                    armed_q <= 1'b0; // a press at the top still uses up the step
                end else if (step_down) begin
                    if (level_q > MIN_LEVEL)
                        level_q <= level_q - 3'd1;
                    armed_q <= 1'b0;
                end else if (key_down[KEY_ENTER]) begin
                    playing_q <= 1'b1; // sticks until reset
                end
            end
        end
        // once playing the level is frozen and the menu ignores all keys
    end

    assign status.playing = playing_q;
    assign status.level   = level_q;

endmodule

`default_nettype wire

/* hdl/player_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

// movement controller for one player
// keeps the sprite pose and runs a timed jump that a collision can cut short
module player_ctrl
    import game_pkg::*;
#(
    parameter int RISE_CYCLES = 50_000_000, // length of the rising part of a jump
    parameter int JUMP_CYCLES = 100_000_000 // length of the whole jump
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           playing, // the player is frozen while this is low
    input  player_keys_t   keys,
    input  logic           collide, // level from the collision logic
    output player_status_t status
);

    // counter sized to hold the full jump length
    localparam int CNT_W = $clog2(JUMP_CYCLES + 1);

    localparam logic [CNT_W-1:0] RISE_LIM = RISE_CYCLES[CNT_W-1:0];
    localparam logic [CNT_W-1:0] JUMP_LIM = JUMP_CYCLES[CNT_W-1:0];

    // the rise must end before the jump does
    if (JUMP_CYCLES <= RISE_CYCLES) begin : g_bad_lengths
        $error("player_ctrl needs JUMP_CYCLES greater than RISE_CYCLES");
    end

    pose_e            pose_q;
    pose_e            pose_d;
    jump_phase_e      phase_q;
    jump_phase_e      phase_d;
    logic [CNT_W-1:0] cnt_q;
    logic [CNT_W-1:0] cnt_d;
    logic [CNT_W-1:0] cnt_inc;
    logic             no_keys;

    assign no_keys = ~(keys.up | keys.left | keys.right);
    assign cnt_inc = cnt_q + 1'b1;

    // pose follows the keys
    // left and right together or a key released mid-jump keep the last pose
    always_comb begin
        pose_d = pose_q;
        if (keys.up && !keys.left && !keys.right)
            pose_d = POSE_UP;
        else if (keys.left && !keys.right)
            pose_d = POSE_LEFT;
        else if (keys.right && !keys.left)
            pose_d = POSE_RIGHT;
        else if (no_keys && (phase_q == PHASE_IDLE))
            pose_d = POSE_STATIC; // back to standing only on the ground
    end

    // jump timing
    // the counter runs through rise and fall and is zero whenever idle
    always_comb begin
        phase_d = phase_q;
        cnt_d   = cnt_q;
        case (phase_q)
            PHASE_IDLE: begin
                if (keys.up) begin
                    phase_d = PHASE_RISE; // sideways keys do not block the take-off
                    cnt_d   = '0;
                end
            end
            PHASE_RISE: begin
                cnt_d = cnt_inc;
                // hitting something overhead ends the rise at once
                if (collide || (cnt_inc >= RISE_LIM))
                    phase_d = PHASE_FALL;
            end
            PHASE_FALL: begin
                if (cnt_inc >= JUMP_LIM) begin
                    phase_d = PHASE_IDLE; // landed
                    cnt_d   = '0;
                end else begin
                    cnt_d = cnt_inc;
                end
            end
            default: begin
                phase_d = PHASE_IDLE; // unused code goes straight back to the ground
                cnt_d   = '0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pose_q  <= POSE_STATIC;
            phase_q <= PHASE_IDLE;
            cnt_q   <= '0;
        end else if (playing) begin
            pose_q  <= pose_d;
            phase_q <= phase_d;
            cnt_q   <= cnt_d;
        end
    end

    assign status.pose  = pose_q;
    assign status.phase = phase_q;

endmodule

`default_nettype wire

/* hdl/game_top.sv */
`timescale 1ns/1ps
`default_nettype none

// game control core
// key map feeds the menu and both player controllers
// a key event shows up on the outputs two cycles after its strobe
module game_top
    import game_pkg::*;
#(
    parameter int RISE_CYCLES = 50_000_000,
    parameter int JUMP_CYCLES = 100_000_000
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           key_valid,
    input  key_event_t     key_event,
    input  logic           p1_collide,
    input  logic           p2_collide,
    output game_status_t   game_status,
    output player_status_t p1_status,
    output player_status_t p2_status
);

    key_map_t     key_down;
    player_keys_t p1_keys;
    player_keys_t p2_keys;

    key_map u_key_map (
        .clk       (clk),
        .rst       (rst),
        .key_valid (key_valid),
        .key_event (key_event),
        .key_down  (key_down)
    );

    level_menu u_menu (
        .clk      (clk),
        .rst      (rst),
        .key_down (key_down),
        .status   (game_status)
    );

    // player 1 plays on the arrow keys
    assign p1_keys.up    = key_down[KEY_UP];
    assign p1_keys.left  = key_down[KEY_LEFT];
    assign p1_keys.right = key_down[KEY_RIGHT];

    // player 2 plays on w, a and d
    assign p2_keys.up    = key_down[KEY_W];
    assign p2_keys.left  = key_down[KEY_A];
    assign p2_keys.right = key_down[KEY_D];

    player_ctrl #(
        .RISE_CYCLES (RISE_CYCLES),
        .JUMP_CYCLES (JUMP_CYCLES)
    ) u_p1 (
        .clk     (clk),
        .rst     (rst),
        .playing (game_status.playing),
        .keys    (p1_keys),
        .collide (p1_collide),
        .status  (p1_status)
    );

    player_ctrl #(
        .RISE_CYCLES (RISE_CYCLES),
        .JUMP_CYCLES (JUMP_CYCLES)
    ) u_p2 (
        .clk     (clk),
        .rst     (rst),
        .playing (game_status.playing),
        .keys    (p2_keys),
        .collide (p2_collide),
        .status  (p2_status)
    );

endmodule

`default_nettype wire

/* tb/game_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

// protocol checks on the outputs of game_top
module game_assertions
    import game_pkg::*;
(
    input logic           clk,
    input logic           rst,
    input game_status_t   game_status,
    input player_status_t p1_status,
    input player_status_t p2_status
);

    // the menu never leaves the legal range of levels
    level_in_range: assert property (@(posedge clk) disable iff (rst)
        (game_status.level >= MIN_LEVEL) && (game_status.level <= MAX_LEVEL))
        else $error("level 0x%0h outside the legal range", game_status.level);

    playing_sticks: assert property (@(posedge clk) disable iff (rst)
        game_status.playing |=> game_status.playing) // only reset leaves the game
        else $error("playing fell without reset");

    // a falling player only lands, it never starts rising again mid-air
    p1_no_fall_to_rise: assert property (@(posedge clk) disable iff (rst)
        (p1_status.phase == PHASE_FALL) |=> (p1_status.phase != PHASE_RISE))
        else $error("player 1 went from fall to rise");

    p2_no_fall_to_rise: assert property (@(posedge clk) disable iff (rst)
        (p2_status.phase == PHASE_FALL) |=> (p2_status.phase != PHASE_RISE))
        else $error("player 2 went from fall to rise");

endmodule

bind game_top game_assertions u_assertions (
    .clk         (clk),
    .rst         (rst),
    .game_status (game_status),
    .p1_status   (p1_status),
    .p2_status   (p2_status)
);

`default_nettype wire

/* tb/game_tb.sv */
`timescale 1ns/1ps
`default_nettype none

// testbench for the game control core
// every stimulus and every expected value comes from the golden file with one command per line
module game_tb
    import game_pkg::*;
();

    localparam string GOLDEN_PATH = "tb/game_golden.txt";

    logic           clk;
    logic           rst;
    logic           key_valid;
    key_event_t     key_event;
    logic           p1_collide;
    logic           p2_collide;
    game_status_t   game_status;
    player_status_t p1_status;
    player_status_t p2_status;

    string lines[$];         // command lines of the golden file without the comments
    int    checks       = 0;
    int    errors       = 0; // all failures of the run
    int    test_errors  = 0; // failures of the test that is running
    int    tests        = 0;
    int    failed_tests = 0;
    int    cycles       = 0;
    int    limit        = 0; // cycle budget worked out from the golden file
    bit    running      = 1'b0;

    // short jumps so a full jump fits in a few lines of the golden file
    game_top #(
        .RISE_CYCLES (8),
        .JUMP_CYCLES (16)
    ) u_dut (
        .clk         (clk),
        .rst         (rst),
        .key_valid   (key_valid),
        .key_event   (key_event),
        .p1_collide  (p1_collide),
        .p2_collide  (p2_collide),
        .game_status (game_status),
        .p1_status   (p1_status),
        .p2_status   (p2_status)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    // the watchdog counts cycles from the end of reset
    always @(posedge clk) begin
        if (running) begin
            cycles = cycles + 1;
            if (cycles > limit) begin
                $display("timeout, the golden file did not finish within %0d cycles", limit);
                $display("ERRORS FOUND");
                $finish;
            end
        end
    end

    task automatic load_golden();
        int    fd;
        string line;
        fd = $fopen(GOLDEN_PATH, "r");
        if (fd == 0) begin
            $display("could not open the golden file %s", GOLDEN_PATH);
            errors = errors + 1;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) != 0) begin
                if ((line.len() > 1) && (line.getc(0) != "#"))
                    lines.push_back(line); // blank lines and comments are dropped here
            end
        end
        $fclose(fd);
    endtask

    // waits plus two cycles per event plus a fixed margin
    function automatic int cycle_budget();
        string cmd;
        int    rc;
        int    key;
        int    n;
        int    total;
        total = 100;
        foreach (lines[i]) begin
            n  = 0;
            rc = $sscanf(lines[i], "%s", cmd);
            if (rc != 1)
                cmd = "";
            if (cmd == "W") begin
                rc = $sscanf(lines[i], "%s %d", cmd, n);
                if (rc == 2)
                    total = total + n;
            end else if (cmd == "K") begin
                rc = $sscanf(lines[i], "%s %h %d", cmd, key, n);
                if (rc == 3)
                    total = total + 4 * n; // a tap is a press and a release
            end else if ((cmd == "P") || (cmd == "R") || (cmd == "C")) begin
                total = total + 2;
            end
        end
        return total;
    endfunction

    // called on a falling edge so the strobe lasts exactly one cycle
    task automatic send_event(input logic is_release, input logic [8:0] code);
        key_valid            = 1'b1;
        key_event.is_release = is_release;
        key_event.code       = code;
        @(negedge clk);
        key_valid = 1'b0;
    endtask

    task automatic set_collide(input int player, input int level);
        if (player == 1)
            p1_collide = level[0];
        else
            p2_collide = level[0];
        @(negedge clk); // the level is sampled on the next rising edge
    endtask

    task automatic check_field(input string name, input int got, input int exp);
        checks = checks + 1;
        if (got != exp) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
            test_errors = test_errors + 1;
        end
    endtask

    task automatic check_outputs(input int arg[6]);
        check_field("game_status.playing", int'(game_status.playing), arg[0]);
        check_field("game_status.level", int'(game_status.level), arg[1]);
        check_field("p1_status.pose", int'(p1_status.pose), arg[2]);
        check_field("p1_status.phase", int'(p1_status.phase), arg[3]);
        check_field("p2_status.pose", int'(p2_status.pose), arg[4]);
        check_field("p2_status.phase", int'(p2_status.phase), arg[5]);
    endtask

    // a line with missing fields is skipped and counted as an error
    task automatic report_bad_line(input string line);
        $display("malformed line in the golden file: %s", line);
        errors = errors + 1;
    endtask

    task automatic finish_test(input string name);
        tests = tests + 1;
        if (test_errors == 0) begin
            $display("test %s passed", name);
        end else begin
            $display("test %s failed with %0d mismatches", name, test_errors);
            failed_tests = failed_tests + 1;
        end
        errors      = errors + test_errors;
        test_errors = 0;
    endtask

    initial begin
        string cmd;
        string name;
        int    rc;
        int    arg[6];
        rst        = 1'b1;
        key_valid  = 1'b0;
        key_event  = '0;
        p1_collide = 1'b0;
        p2_collide = 1'b0;
        load_golden();
        limit = cycle_budget();
        repeat (3) @(negedge clk);
        rst     = 1'b0;
        running = 1'b1;
        // every command starts and ends on a falling edge where outputs are stable
        foreach (lines[i]) begin
            rc = $sscanf(lines[i], "%s", cmd);
            if (rc != 1)
                cmd = "";
            case (cmd)
                "P", "R": begin
                    rc = $sscanf(lines[i], "%s %h", cmd, arg[0]);
                    if (rc == 2)
                        send_event(cmd == "R", arg[0][8:0]);
                    else
                        report_bad_line(lines[i]);
                end
                "K": begin
                    rc = $sscanf(lines[i], "%s %h %d", cmd, arg[0], arg[1]);
                    if (rc == 3) begin
                        repeat (arg[1]) begin
                            send_event(1'b0, arg[0][8:0]);
                            send_event(1'b1, arg[0][8:0]);
                        end
                    end else begin
                        report_bad_line(lines[i]);
                    end
                end
                "C": begin
                    rc = $sscanf(lines[i], "%s %d %d", cmd, arg[0], arg[1]);
                    if (rc == 3)
                        set_collide(arg[0], arg[1]);
                    else
                        report_bad_line(lines[i]);
                end
                "W": begin
                    rc = $sscanf(lines[i], "%s %d", cmd, arg[0]);
                    if (rc == 2)
                        repeat (arg[0]) @(negedge clk);
                    else
                        report_bad_line(lines[i]);
                end
                "E": begin
                    rc = $sscanf(lines[i], "%s %h %h %h %h %h %h", cmd,
                                 arg[0], arg[1], arg[2], arg[3], arg[4], arg[5]);
                    if (rc == 7)
                        check_outputs(arg);
                    else
                        report_bad_line(lines[i]);
                end
                "T": begin
                    rc = $sscanf(lines[i], "%s %s", cmd, name);
                    if (rc == 2)
                        finish_test(name);
                    else
                        report_bad_line(lines[i]);
                end
                default: begin
                    $display("unknown command in the golden file: %s", cmd);
                    errors = errors + 1;
                end
            endcase
        end
        errors = errors + test_errors; // checks after the last test line still count
        $display("%0d tests, %0d failed, %0d checks, %0d errors",
                 tests, failed_tests, checks, errors);
        if ((errors == 0) && (checks > 0)) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb/game_golden.txt */
# P code / R code: press / release (code hex), K code n: n taps, C player level: collide
# W n: wait n cycles, E playing level p1_pose p1_phase p2_pose p2_phase (hex), T name: test end
E 0 1 6 0 6 0
T reset_values
K 01D 6
W 1
E 0 5 6 0 6 0
K 072 5
W 1
E 0 1 6 0 6 0
T menu_limits
P 075
W 2
E 0 2 6 0 6 0
P 01D
W 2
R 01D
R 075
K 029 1
W 2
E 0 2 6 0 6 0
T one_step_per_press
P 06B
P 01C
W 2
E 0 2 6 0 6 0
R 06B
R 01C
K 05A 1
K 01D 1
W 1
E 1 2 6 0 8 1
W 20
E 1 2 6 0 6 0
T start_and_freeze
P 06B
P 174
W 2
E 1 2 2 0 6 0
R 06B
P 01C
W 2
E 1 2 7 0 2 0
R 174
R 01C
W 2
E 1 2 6 0 6 0
T pose_rule
K 075 1
W 4
E 1 2 8 1 6 0
W 8
E 1 2 8 2 6 0
W 8
E 1 2 6 0 6 0
T full_jump
K 075 1
W 2
E 1 2 8 1 6 0
C 1 1
W 2
E 1 2 8 2 6 0
C 1 0
W 4
E 1 2 8 2 6 0
W 8
E 1 2 6 0 6 0
T jump_cut_by_collide

/* flist.f */
hdl/game_pkg.sv
hdl/key_map.sv
hdl/level_menu.sv
hdl/player_ctrl.sv
hdl/game_top.sv
tb/game_assertions.sv
tb/game_tb.sv

/* Makefile */
# Verilator build and run for the game control core

VERILATOR ?= verilator
TOP       ?= game_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= NO ERRORS

SIM := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FLIST) $(shell cat $(FLIST))
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

# the simulation runs from the project root so the golden file path resolves
run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
